// ==== compile.f ====
fsctl_pkg.sv
fsctl_decode.sv
fsctl_stream_cfg.sv
fsctl_motor_ctl.sv
fsctl_readback.sv
fsctl_top.sv
tb_fsctl.sv

// ==== Makefile ====
TOP := tb_fsctl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary -j 0 -Wno-fatal -f compile.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// ==== tb_fsctl.sv ====
module tb_fsctl import fsctl_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic                        o_clk;
	logic                        o_resetn;
	logic                        i_wr_en;
	logic [IDX_W-1:0]            i_wr_addr;
	logic [DATA_W-1:0]           i_wr_data;
	logic                        i_rd_en;
	logic [IDX_W-1:0]            i_rd_addr;
	logic                        i_fsync;
	motor_sts_t [MOTOR_NBR-1:0] i_motor_sts;
	logic [DATA_W-1:0]           o_rd_data;
	logic                        o_fsync;
	logic                        o_soft_resetn;
	logic                        o_order_1over2;
	logic [STREAM_NBR-1:0]       o_stream_resetn;
	stream_geom_t                o_s1_geom;
	stream_geom_t                o_s2_geom;
	motor_ctl_t [MOTOR_NBR-1:0] o_motor;

	integer seed = 32'haad4_3f60;
	int     checks = 0;
	int     errors = 0;
	int     test_errors = 0;
	string  test_name;

	// ----------------------------------------
	// reference model state
	logic              m_soft;
	logic              m_busy;
	logic [3:0]        m_disp;
	logic [DATA_W-1:0] st_word [2][GEOM_WORDS];
	stream_geom_t      act_geom [2];
	logic              act_order;
	logic [2:0]        act_resetn;
	logic              m_xen [MOTOR_NBR];
	logic              m_xrst [MOTOR_NBR];
	logic [MS_W-1:0]   m_ms [MOTOR_NBR];
	logic              m_dir [MOTOR_NBR];
	logic [15:0]       m_step [MOTOR_NBR];
	logic [15:0]       m_speed [MOTOR_NBR];

	fsctl_top UUT (.*);

	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	function automatic void model_reset();
		int k;
		m_soft = 1'b0;
		m_busy = 1'b0;
		// stream 0 running out of reset
		m_disp = 4'b0010;
		for (k = 0; k < GEOM_WORDS; k++) begin
			st_word[0][k] = '0;
			st_word[1][k] = '0;
		end
		act_geom[0] = '0;
		act_geom[1] = '0;
		act_order   = 1'b0;
		act_resetn  = '0;
		for (k = 0; k < MOTOR_NBR; k++) begin
			m_xen[k]   = 1'b0;
			m_xrst[k]  = 1'b0;
			m_ms[k]    = '0;
			m_dir[k]   = 1'b0;
			m_step[k]  = '0;
			m_speed[k] = '0;
		end
	endfunction

	// stream 2 words follow stream 1 directly at indices 2 to 11
	function automatic void model_write(input logic [IDX_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		int idx;
		int k;
		if (addr == REG_CTRL) begin
			m_soft = data[0];
			m_busy = data[1];
		end else if (addr == REG_DISP) begin
			m_disp = data[3:0];
		end else if (addr >= REG_S1_BASE && addr < REG_S2_BASE + 8'd5) begin
			idx = int'(addr - REG_S1_BASE);
			st_word[idx / 5][idx % 5] = data & 32'h0fff_0fff;
		end else if (addr == REG_MT_ENRST) begin
			for (k = 0; k < MOTOR_NBR; k++) begin
				m_xen[k]  = data[4*k];
				m_xrst[k] = data[4*k+1];
			end
		end else if (addr == REG_MT_MS) begin
			for (k = 0; k < MOTOR_NBR; k++)
				m_ms[k] = data[4*k +: 3];
		end else if (addr == REG_MT_DIR) begin
			for (k = 0; k < MOTOR_NBR; k++)
				m_dir[k] = data[4*k];
		end else if (addr >= REG_MT_STEP_BASE && addr < REG_MT_STEP_BASE + 8'd4) begin
			m_step[int'(addr - REG_MT_STEP_BASE)] = data[15:0];
		end else if (addr >= REG_MT_SPEED_BASE && addr < REG_MT_SPEED_BASE + 8'd4) begin
			m_speed[int'(addr - REG_MT_SPEED_BASE)] = data[15:0];
		end
	endfunction

	function automatic logic [DATA_W-1:0] expected_read(input logic [IDX_W-1:0] addr);
		logic [DATA_W-1:0] w;
		int idx;
		int k;
		w = '0;
		if (addr == REG_CTRL) begin
			w[1:0] = {m_busy, m_soft};
		end else if (addr == REG_DISP) begin
			w[3:0] = m_disp;
		end else if (addr >= REG_S1_BASE && addr < REG_S2_BASE + 8'd5) begin
			idx = int'(addr - REG_S1_BASE);
			w = st_word[idx / 5][idx % 5];
		end else if (addr == REG_MT_ENRST) begin
			for (k = 0; k < MOTOR_NBR; k++)
				w[4*k +: 2] = {m_xrst[k], m_xen[k]};
		end else if (addr == REG_MT_STATE) begin
			for (k = 0; k < MOTOR_NBR; k++)
				w[4*k +: 3] = {i_motor_sts[k].state, i_motor_sts[k].tpsign,
					i_motor_sts[k].zpsign};
		end else if (addr == REG_MT_MS) begin
			for (k = 0; k < MOTOR_NBR; k++)
				w[4*k +: 3] = m_ms[k];
		end else if (addr == REG_MT_DIR) begin
			for (k = 0; k < MOTOR_NBR; k++)
				w[4*k] = m_dir[k];
		end else if (addr >= REG_MT_STEP_BASE && addr < REG_MT_STEP_BASE + 8'd4) begin
			w[15:0] = m_step[int'(addr - REG_MT_STEP_BASE)];
		end else if (addr >= REG_MT_SPEED_BASE && addr < REG_MT_SPEED_BASE + 8'd4) begin
			w[15:0] = m_speed[int'(addr - REG_MT_SPEED_BASE)];
		end else if (addr == REG_VERSION) begin
			w = CORE_VERSION;
		end
		return w;
	endfunction

	// x in the low field, y in the high field of each word
	function automatic stream_geom_t assemble_geom(input int s);
		stream_geom_t g;
		g.width      = st_word[s][0][11:0];
		g.height     = st_word[s][0][27:16];
		g.win_left   = st_word[s][1][11:0];
		g.win_top    = st_word[s][1][27:16];
		g.win_width  = st_word[s][2][11:0];
		g.win_height = st_word[s][2][27:16];
		g.dst_left   = st_word[s][3][11:0];
		g.dst_top    = st_word[s][3][27:16];
		g.dst_width  = st_word[s][4][11:0];
		g.dst_height = st_word[s][4][27:16];
		return g;
	endfunction

	function automatic void model_fsync();
		if (!m_busy) begin
			act_geom[0] = assemble_geom(0);
			act_geom[1] = assemble_geom(1);
			act_order   = m_disp[0];
			act_resetn  = m_disp[3:1];
		end
	endfunction

	function automatic logic [IDX_W-1:0] pick_motor_addr();
		int p;
		p = rand_below(11);
		case (p)
			0: return REG_MT_ENRST;
			1: return REG_MT_MS;
			2: return REG_MT_DIR;
			3, 4, 5, 6: return REG_MT_STEP_BASE + 8'(p - 3);
			default: return REG_MT_SPEED_BASE + 8'(p - 7);
		endcase
	endfunction

	function automatic logic [IDX_W-1:0] unmapped_addr();
		if (rand_below(2) == 0)
			return 8'd12 + 8'(rand_below(22));
		else
			return 8'd59 + 8'(rand_below(196));
	endfunction

	// ----------------------------------------
	// checking and reporting
	task automatic check_value(input string what, input logic [127:0] exp,
		input logic [127:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			test_errors++;
			$display("MISMATCH %s %s: expected %0h actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		test_errors++;
		$display("ERROR %s: %s", test_name, what);
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0)
			$display("test %s: ok", test_name);
		else
			$display("test %s: failed with %0d errors", test_name, test_errors);
	endtask

	// ----------------------------------------
	// bus access
	task automatic write_reg(input logic [IDX_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(posedge o_clk);
		i_wr_en   <= 1'b1;
		i_wr_addr <= addr;
		i_wr_data <= data;
		@(posedge o_clk);
		i_wr_en <= 1'b0;
		model_write(addr, data);
	endtask

	task automatic check_read(input logic [IDX_W-1:0] addr);
		@(posedge o_clk);
		i_rd_en   <= 1'b1;
		i_rd_addr <= addr;
		@(posedge o_clk);
		i_rd_en <= 1'b0;
		@(negedge o_clk);
		check_value($sformatf("read %0d", addr), 128'(expected_read(addr)), 128'(o_rd_data));
	endtask

	task automatic check_motors();
		int k;
		for (k = 0; k < MOTOR_NBR; k++)
			check_value($sformatf("motor %0d", k),
				128'({m_xen[k], m_xrst[k], m_ms[k], m_dir[k], m_step[k], m_speed[k]}),
				128'({o_motor[k].xen, o_motor[k].xrst, o_motor[k].ms, o_motor[k].dir,
					o_motor[k].step, o_motor[k].speed}));
	endtask

	task automatic check_active();
		check_value("s1 geometry", 128'(act_geom[0]), 128'(o_s1_geom));
		check_value("s2 geometry", 128'(act_geom[1]), 128'(o_s2_geom));
		check_value("order", 128'(act_order), 128'(o_order_1over2));
		check_value("stream resets", 128'(act_resetn), 128'(o_stream_resetn));
		check_value("soft reset", 128'(m_soft), 128'(o_soft_resetn));
	endtask

	// raise i_fsync, check the active copy in the o_fsync cycle
	task automatic frame_sync();
		int   n;
		logic seen;
		seen = 1'b0;
		@(posedge o_clk);
		i_fsync <= 1'b1;
		model_fsync();
		for (n = 0; n < 20 && !seen; n++) begin
			@(negedge o_clk);
			seen = o_fsync;
		end
		if (seen)
			check_active();
		else
			report_failure("o_fsync did not pulse within 20 cycles of the frame sync");
		@(negedge o_clk);
		if (seen && o_fsync)
			report_failure("o_fsync stayed high for more than one cycle");
		@(posedge o_clk);
		i_fsync <= 1'b0;
		repeat (4) @(posedge o_clk);
	endtask

	// ----------------------------------------
	task automatic test_reset();
		int k;
		begin_test("reset_state");
		@(negedge o_clk);
		check_value("control outputs", 128'(0),
			128'({o_fsync, o_soft_resetn, o_order_1over2, o_stream_resetn}));
		check_value("s1 geometry", 128'(0), 128'(o_s1_geom));
		check_value("s2 geometry", 128'(0), 128'(o_s2_geom));
		check_value("read data", 128'(0), 128'(o_rd_data));
		for (k = 0; k < MOTOR_NBR; k++)
			check_value($sformatf("motor %0d", k), 128'(0), 128'(o_motor[k]));
		check_read(REG_VERSION);
		check_read(REG_CTRL);
		check_read(REG_DISP);
		end_test();
	endtask

	task automatic test_motor_random();
		logic [IDX_W-1:0] addr;
		int i;
		begin_test("motor_random");
		for (i = 0; i < 200; i++) begin
			addr = pick_motor_addr();
			write_reg(addr, rand_word());
			repeat (2) @(posedge o_clk);
			@(negedge o_clk);
			check_motors();
			check_read(addr);
			if (i % 8 == 0)
				check_read(unmapped_addr());
		end
		end_test();
	endtask

	task automatic test_start_stop();
		logic [DATA_W-1:0] data;
		int n_start [MOTOR_NBR];
		int n_stop [MOTOR_NBR];
		int i;
		int c;
		int k;
		begin_test("start_stop");
		for (i = 0; i < 40; i++) begin
			data = rand_word();
			for (k = 0; k < MOTOR_NBR; k++) begin
				n_start[k] = 0;
				n_stop[k]  = 0;
			end
			write_reg(REG_MT_STARTSTOP, data);
			// count pulse cycles over a window wider than the pipeline
			for (c = 0; c < 6; c++) begin
				@(negedge o_clk);
				for (k = 0; k < MOTOR_NBR; k++) begin
					n_start[k] += int'(o_motor[k].start);
					n_stop[k]  += int'(o_motor[k].stop);
				end
			end
			for (k = 0; k < MOTOR_NBR; k++) begin
				check_value($sformatf("motor %0d start cycles", k), 128'(data[4*k]),
					128'(n_start[k]));
				check_value($sformatf("motor %0d stop cycles", k), 128'(data[4*k+1]),
					128'(n_stop[k]));
			end
			check_motors();
			check_read(REG_MT_STARTSTOP);
		end
		end_test();
	endtask

	task automatic test_sensors();
		logic [DATA_W-1:0] r;
		int i;
		begin_test("sensor_readback");
		for (i = 0; i < 20; i++) begin
			r = rand_word();
			@(posedge o_clk);
			i_motor_sts <= r[3*MOTOR_NBR-1:0];
			check_read(REG_MT_STATE);
		end
		end_test();
	endtask

	task automatic test_staged_geom();
		logic [DATA_W-1:0] r;
		int i;
		int j;
		begin_test("staged_geometry");
		for (j = 0; j < 4; j++) begin
			r = rand_word();
			write_reg(REG_CTRL, r & 32'h1);
			for (i = 0; i < 12; i++)
				write_reg(REG_DISP + 8'(rand_below(11)), rand_word());
			repeat (2) @(posedge o_clk);
			@(negedge o_clk);
			// active copy must not move before the frame sync
			check_active();
			check_read(REG_CTRL);
			for (i = 1; i < 12; i++)
				check_read(8'(i));
			frame_sync();
		end
		end_test();
	endtask

	task automatic test_busy_gating();
		int i;
		begin_test("busy_gating");
		write_reg(REG_CTRL, 32'h3);
		check_read(REG_CTRL);
		for (i = 0; i < 10; i++)
			write_reg(REG_DISP + 8'(rand_below(11)), rand_word());
		repeat (2) @(posedge o_clk);
		frame_sync();
		write_reg(REG_CTRL, 32'h1);
		frame_sync();
		end_test();
	endtask

	// ----------------------------------------
	initial begin
		o_resetn    <= 1'b0;
		i_wr_en     <= 1'b0;
		i_wr_addr   <= '0;
		i_wr_data   <= '0;
		i_rd_en     <= 1'b0;
		i_rd_addr   <= '0;
		i_fsync     <= 1'b0;
		i_motor_sts <= '0;
		model_reset();
		repeat (10) @(posedge o_clk);
		o_resetn <= 1'b1;

		test_reset();
		test_motor_random();
		test_start_stop();
		test_sensors();
		test_staged_geom();
		test_busy_gating();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== fsctl_top.sv ====
module fsctl_top import fsctl_pkg::*; (
	input  logic                        o_clk,
	input  logic                        o_resetn,
	input  logic                        i_wr_en,
	input  logic [IDX_W-1:0]            i_wr_addr,
	input  logic [DATA_W-1:0]           i_wr_data,
	input  logic                        i_rd_en,
	input  logic [IDX_W-1:0]            i_rd_addr,
	input  logic                        i_fsync,
	input  motor_sts_t [MOTOR_NBR-1:0] i_motor_sts,
	output logic [DATA_W-1:0]           o_rd_data,
	output logic                        o_fsync,
	output logic                        o_soft_resetn,
	output logic                        o_order_1over2,
	output logic [STREAM_NBR-1:0]       o_stream_resetn,
	output stream_geom_t                o_s1_geom,
	output stream_geom_t                o_s2_geom,
	output motor_ctl_t [MOTOR_NBR-1:0] o_motor
);

	wr_sel_t      wr;
	logic         cfg_busy;
	logic [3:0]   disp_stage;
	stream_geom_t s1_stage;
	stream_geom_t s2_stage;

	// ----------------------------------------
	fsctl_decode u_decode (
		.o_clk     (o_clk),
		.o_resetn  (o_resetn),
		.i_wr_en   (i_wr_en),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data),
		.o_wr      (wr)
	);

	// running bits also read back through the display word
	fsctl_stream_cfg u_stream_cfg (
		.o_clk           (o_clk),
		.o_resetn        (o_resetn),
		.i_wr            (wr),
		.i_fsync         (i_fsync),
		.o_fsync         (o_fsync),
		.o_soft_resetn   (o_soft_resetn),
		.o_cfg_busy      (cfg_busy),
		.o_order_1over2  (o_order_1over2),
		.o_running       (),
		.o_stream_resetn (o_stream_resetn),
		.o_s1_geom       (o_s1_geom),
		.o_s2_geom       (o_s2_geom),
		.o_s1_stage      (s1_stage),
		.o_s2_stage      (s2_stage),
		.o_disp_stage    (disp_stage)
	);

	fsctl_motor_ctl u_motor_ctl (
		.o_clk    (o_clk),
		.o_resetn (o_resetn),
		.i_wr     (wr),
		.o_motor  (o_motor)
	);

	fsctl_readback u_readback (
		.o_clk         (o_clk),
		.o_resetn      (o_resetn),
		.i_rd_en       (i_rd_en),
		.i_rd_addr     (i_rd_addr),
		.i_soft_resetn (o_soft_resetn),
		.i_cfg_busy    (cfg_busy),
		.i_disp_stage  (disp_stage),
		.i_s1_stage    (s1_stage),
		.i_s2_stage    (s2_stage),
		.i_motor       (o_motor),
		.i_motor_sts   (i_motor_sts),
		.o_rd_data     (o_rd_data)
	);

endmodule

// ==== fsctl_readback.sv ====
module fsctl_readback import fsctl_pkg::*; (
	input  logic                        o_clk,
	input  logic                        o_resetn,
	input  logic                        i_rd_en,
	input  logic [IDX_W-1:0]            i_rd_addr,
	input  logic                        i_soft_resetn,
	input  logic                        i_cfg_busy,
	input  logic [3:0]                  i_disp_stage,
	input  stream_geom_t                i_s1_stage,
	input  stream_geom_t                i_s2_stage,
	input  motor_ctl_t [MOTOR_NBR-1:0] i_motor,
	input  motor_sts_t [MOTOR_NBR-1:0] i_motor_sts,
	output logic [DATA_W-1:0]           o_rd_data
);

	logic [DATA_W-1:0] rd_word;

	// same packing as the write side
	function automatic img_pair_t geom_get(input stream_geom_t g, input logic [2:0] sub);
		img_pair_t p;
		p = '0;
		case (sub)
			3'd0: {p.y, p.x} = {g.height, g.width};
			3'd1: {p.y, p.x} = {g.win_top, g.win_left};
			3'd2: {p.y, p.x} = {g.win_height, g.win_width};
			3'd3: {p.y, p.x} = {g.dst_top, g.dst_left};
			3'd4: {p.y, p.x} = {g.dst_height, g.dst_width};
			default: p = '0;
		endcase
		return p;
	endfunction

	always_comb begin
		motor_nib_t          nib;
		logic [MT_SEL_W-1:0] mt;
		nib = '0;
		mt = '0;
		rd_word = '0;
		case (i_rd_addr)
			REG_CTRL: rd_word[1:0] = {i_cfg_busy, i_soft_resetn};
			REG_DISP: rd_word[3:0] = i_disp_stage;
			REG_MT_ENRST: begin
				for (int k = 0; k < MOTOR_NBR; k++)
					nib[k] = {2'b00, i_motor[k].xrst, i_motor[k].xen};
				rd_word = nib;
			end
			REG_MT_STATE: begin
				for (int k = 0; k < MOTOR_NBR; k++)
					nib[k] = {1'b0, i_motor_sts[k].state, i_motor_sts[k].tpsign,
						i_motor_sts[k].zpsign};
				rd_word = nib;
			end
			REG_MT_MS: begin
				for (int k = 0; k < MOTOR_NBR; k++)
					nib[k] = {1'b0, i_motor[k].ms};
				rd_word = nib;
			end
			REG_MT_DIR: begin
				for (int k = 0; k < MOTOR_NBR; k++)
					nib[k] = {3'b000, i_motor[k].dir};
				rd_word = nib;
			end
			REG_VERSION: rd_word = CORE_VERSION;
			default: begin
				if (idx_in(i_rd_addr, REG_S1_BASE, GEOM_WORDS)) begin
					rd_word = geom_get(i_s1_stage, 3'(i_rd_addr - REG_S1_BASE));
				end else if (idx_in(i_rd_addr, REG_S2_BASE, GEOM_WORDS)) begin
					rd_word = geom_get(i_s2_stage, 3'(i_rd_addr - REG_S2_BASE));
				end else if (idx_in(i_rd_addr, REG_MT_STEP_BASE, MOTOR_NBR)) begin
					mt = MT_SEL_W'(i_rd_addr - REG_MT_STEP_BASE);
					rd_word[STEP_W-1:0] = i_motor[mt].step;
				end else if (idx_in(i_rd_addr, REG_MT_SPEED_BASE, MOTOR_NBR)) begin
					mt = MT_SEL_W'(i_rd_addr - REG_MT_SPEED_BASE);
					rd_word[SPEED_W-1:0] = i_motor[mt].speed;
				end
			end
		endcase
	end

	// held until the next read
	always_ff @(posedge o_clk) begin
		if (!o_resetn)
			o_rd_data <= '0;
		else if (i_rd_en)
			o_rd_data <= rd_word;
	end

endmodule

// ==== fsctl_motor_ctl.sv ====
module fsctl_motor_ctl import fsctl_pkg::*; (
	input  logic                        o_clk,
	input  logic                        o_resetn,
	input  wr_sel_t                     i_wr,
	output motor_ctl_t [MOTOR_NBR-1:0] o_motor
);

	motor_nib_t         nib;
	logic [STEP_W-1:0]  wr_step;
	logic [SPEED_W-1:0] wr_speed;

	assign nib      = i_wr.word.nib;
	assign wr_step  = i_wr.word.pair[STEP_W-1:0];
	assign wr_speed = i_wr.word.pair[SPEED_W-1:0];

	// ----------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_motor <= '0;
		end else begin
			for (int k = 0; k < MOTOR_NBR; k++) begin
				// start and stop last one cycle
				o_motor[k].start <= 1'b0;
				o_motor[k].stop  <= 1'b0;

				if (i_wr.mt_enrst) begin
					o_motor[k].xen  <= nib[k][0];
					o_motor[k].xrst <= nib[k][1];
				end
				if (i_wr.mt_startstop) begin
					o_motor[k].start <= nib[k][0];
					o_motor[k].stop  <= nib[k][1];
				end
				if (i_wr.mt_ms)
					o_motor[k].ms <= nib[k][MS_W-1:0];
				if (i_wr.mt_dir)
					o_motor[k].dir <= nib[k][0];

				// full word with one index per motor
				if (i_wr.mt_step && i_wr.sub == 3'(k))
					o_motor[k].step <= wr_step;
				if (i_wr.mt_speed && i_wr.sub == 3'(k))
					o_motor[k].speed <= wr_speed;
			end
		end
	end

endmodule

// ==== fsctl_stream_cfg.sv ====
module fsctl_stream_cfg import fsctl_pkg::*; (
	input  logic                  o_clk,
	input  logic                  o_resetn,
	input  wr_sel_t               i_wr,
	input  logic                  i_fsync,
	output logic                  o_fsync,
	output logic                  o_soft_resetn,
	output logic                  o_cfg_busy,
	output logic                  o_order_1over2,
	output logic [STREAM_NBR-1:0] o_running,
	output logic [STREAM_NBR-1:0] o_stream_resetn,
	output stream_geom_t          o_s1_geom,
	output stream_geom_t          o_s2_geom,
	output stream_geom_t          o_s1_stage,
	output stream_geom_t          o_s2_stage,
	output logic [3:0]            o_disp_stage
);

	logic [3:0] low_nib;
	logic       fsync_meta;
	logic       fsync_sync;
	logic       fsync_prev;
	logic       fsync_rise;
	logic       cfg_load;

	// merge one geometry word into the staged set
	function automatic stream_geom_t geom_put(input stream_geom_t g, input logic [2:0] sub,
		input img_pair_t p);
		stream_geom_t r;
		r = g;
		case (sub)
			3'd0: begin
				r.width  = p.x;
				r.height = p.y;
			end
			3'd1: begin
				r.win_left = p.x;
				r.win_top  = p.y;
			end
			3'd2: begin
				r.win_width  = p.x;
				r.win_height = p.y;
			end
			3'd3: begin
				r.dst_left = p.x;
				r.dst_top  = p.y;
			end
			3'd4: begin
				r.dst_width  = p.x;
				r.dst_height = p.y;
			end
			default: r = g;
		endcase
		return r;
	endfunction

	assign low_nib   = i_wr.word.nib[0];
	assign o_running = o_disp_stage[3:1];

	// ----------------------------------------
	// control and staging registers
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_soft_resetn <= CTRL_RST[0];
			o_cfg_busy    <= CTRL_RST[1];
			o_disp_stage  <= DISP_RST;
			o_s1_stage    <= '0;
			o_s2_stage    <= '0;
		end else begin
			if (i_wr.ctrl) begin
				o_soft_resetn <= low_nib[0];
				o_cfg_busy    <= low_nib[1];
			end
			if (i_wr.disp)
				o_disp_stage <= low_nib;
			if (i_wr.s1)
				o_s1_stage <= geom_put(o_s1_stage, i_wr.sub, i_wr.word.pair);
			if (i_wr.s2)
				o_s2_stage <= geom_put(o_s2_stage, i_wr.sub, i_wr.word.pair);
		end
	end

	// ----------------------------------------
	// two sync flops then edge detect on frame sync
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			fsync_meta <= 1'b0;
			fsync_sync <= 1'b0;
			fsync_prev <= 1'b0;
			o_fsync    <= 1'b0;
		end else begin
			fsync_meta <= i_fsync;
			fsync_sync <= fsync_meta;
			fsync_prev <= fsync_sync;
			o_fsync    <= fsync_rise;
		end
	end

	assign fsync_rise = fsync_sync & ~fsync_prev;
	// busy holds off the transfer but not o_fsync
	assign cfg_load   = fsync_rise & ~o_cfg_busy;

	// active copy lands together with o_fsync
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_order_1over2  <= 1'b0;
			o_stream_resetn <= '0;
			o_s1_geom       <= '0;
			o_s2_geom       <= '0;
		end else if (cfg_load) begin
			o_order_1over2  <= o_disp_stage[0];
			o_stream_resetn <= o_running;
			o_s1_geom       <= o_s1_stage;
			o_s2_geom       <= o_s2_stage;
		end
	end

endmodule

// ==== fsctl_decode.sv ====
module fsctl_decode import fsctl_pkg::*; (
	input  logic              o_clk,
	input  logic              o_resetn,
	input  logic              i_wr_en,
	input  logic [IDX_W-1:0]  i_wr_addr,
	input  logic [DATA_W-1:0] i_wr_data,
	output wr_sel_t           o_wr
);

	wr_sel_t nxt;

	// ----------------------------------------
	// index match with at most one strobe per write
	always_comb begin
		nxt = '0;
		nxt.word = i_wr_data;
		if (i_wr_en) begin
			case (i_wr_addr)
				REG_CTRL:         nxt.ctrl = 1'b1;
				REG_DISP:         nxt.disp = 1'b1;
				REG_MT_ENRST:     nxt.mt_enrst = 1'b1;
				REG_MT_STARTSTOP: nxt.mt_startstop = 1'b1;
				REG_MT_MS:        nxt.mt_ms = 1'b1;
				REG_MT_DIR:       nxt.mt_dir = 1'b1;
				default: begin
					if (idx_in(i_wr_addr, REG_S1_BASE, GEOM_WORDS)) begin
						nxt.s1 = 1'b1;
						nxt.sub = 3'(i_wr_addr - REG_S1_BASE);
					end else if (idx_in(i_wr_addr, REG_S2_BASE, GEOM_WORDS)) begin
						nxt.s2 = 1'b1;
						nxt.sub = 3'(i_wr_addr - REG_S2_BASE);
					end else if (idx_in(i_wr_addr, REG_MT_STEP_BASE, MOTOR_NBR)) begin
						nxt.mt_step = 1'b1;
						nxt.sub = 3'(i_wr_addr - REG_MT_STEP_BASE);
					end else if (idx_in(i_wr_addr, REG_MT_SPEED_BASE, MOTOR_NBR)) begin
						nxt.mt_speed = 1'b1;
						nxt.sub = 3'(i_wr_addr - REG_MT_SPEED_BASE);
					end
					// state and version are read only, rest unmapped
				end
			endcase
		end
	end

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_wr <= '0;
		end else begin
			o_wr <= nxt;
		end
	end

endmodule

// ==== fsctl_pkg.sv ====
package fsctl_pkg;

	// ----------------------------------------
	// sizes
	localparam int DATA_W     = 32;
	localparam int IDX_W      = 8;
	localparam int IMG_W      = 12;
	localparam int STEP_W     = 16;
	localparam int SPEED_W    = 16;
	localparam int MS_W       = 3;
	localparam int MOTOR_NBR  = 4;
	localparam int STREAM_NBR = 3;
	localparam int MT_SEL_W   = $clog2(MOTOR_NBR);
	localparam int GEOM_WORDS = 5;

	localparam logic [DATA_W-1:0] CORE_VERSION = 32'hFF00_FF00;

	// ----------------------------------------
	// register map
	localparam logic [IDX_W-1:0] REG_CTRL          = 8'd0;
	localparam logic [IDX_W-1:0] REG_DISP          = 8'd1;
	localparam logic [IDX_W-1:0] REG_S1_BASE       = 8'd2;
	localparam logic [IDX_W-1:0] REG_S2_BASE       = 8'd7;
	localparam logic [IDX_W-1:0] REG_MT_ENRST      = 8'd34;
	localparam logic [IDX_W-1:0] REG_MT_STATE      = 8'd35;
	localparam logic [IDX_W-1:0] REG_MT_STARTSTOP  = 8'd36;
	localparam logic [IDX_W-1:0] REG_MT_MS         = 8'd37;
	localparam logic [IDX_W-1:0] REG_MT_DIR        = 8'd38;
	localparam logic [IDX_W-1:0] REG_MT_STEP_BASE  = 8'd47;
	localparam logic [IDX_W-1:0] REG_MT_SPEED_BASE = 8'd55;
	localparam logic [IDX_W-1:0] REG_VERSION       = 8'd255;

	// control reset value with busy in bit 1 and soft reset in bit 0
	localparam logic [1:0] CTRL_RST = 2'b00;
	// order in bit 0 and s0 to s2 running above it
	localparam logic [3:0] DISP_RST = 4'b0010;

	// ----------------------------------------
	typedef struct packed {
		logic [3:0]       pad_hi;
		logic [IMG_W-1:0] y;
		logic [3:0]       pad_lo;
		logic [IMG_W-1:0] x;
	} img_pair_t;

	typedef logic [7:0][3:0] motor_nib_t;

	// geometry sees a coordinate pair, motor groups see nibbles
	typedef union packed {
		img_pair_t  pair;
		motor_nib_t nib;
	} wr_word_u;

	typedef struct packed {
		logic     ctrl;
		logic     disp;
		logic     s1;
		logic     s2;
		logic     mt_enrst;
		logic     mt_startstop;
		logic     mt_ms;
		logic     mt_dir;
		logic     mt_step;
		logic     mt_speed;
		logic [2:0] sub;
		wr_word_u word;
	} wr_sel_t;

	typedef struct packed {
		logic [IMG_W-1:0] width;
		logic [IMG_W-1:0] height;
		logic [IMG_W-1:0] win_left;
		logic [IMG_W-1:0] win_top;
		logic [IMG_W-1:0] win_width;
		logic [IMG_W-1:0] win_height;
		logic [IMG_W-1:0] dst_left;
		logic [IMG_W-1:0] dst_top;
		logic [IMG_W-1:0] dst_width;
		logic [IMG_W-1:0] dst_height;
	} stream_geom_t;

	typedef struct packed {
		logic               xen;
		logic               xrst;
		logic               start;
		logic               stop;
		logic [MS_W-1:0]    ms;
		logic               dir;
		logic [STEP_W-1:0]  step;
		logic [SPEED_W-1:0] speed;
	} motor_ctl_t;

	typedef struct packed {
		logic zpsign;
		logic tpsign;
		logic state;
	} motor_sts_t;

	// true when addr falls in [base, base + n)
	function automatic logic idx_in(input logic [IDX_W-1:0] addr,
		input logic [IDX_W-1:0] base, input int unsigned n);
		return (addr >= base) && (addr < base + n);
	endfunction

endpackage
